/* logic/cpu_pkg.sv */
package cpu_pkg;

    // architectural register file size and the width of a register index
    localparam int REG_COUNT = 16;
    localparam int REG_AW = $clog2(REG_COUNT);

    // s0 to s3, the stages that hold decoded microcode
    localparam int NUM_STAGES = 4;

    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_ADD   = 4'd1,
        OP_SUB   = 4'd2,
        OP_AND   = 4'd3,
        OP_OR    = 4'd4,
        OP_XOR   = 4'd5,
        OP_ADDI  = 4'd6,
        OP_LOAD  = 4'd7,
        OP_STORE = 4'd8,
        OP_BEQ   = 4'd9,
        OP_BNE   = 4'd10,
        OP_BLT   = 4'd11,
        OP_BGEU  = 4'd12,
        OP_JAL   = 4'd13,
        OP_HALT  = 4'd14
    } opcode_e;

    typedef enum logic [2:0] {
        CMP_NULL = 3'd0,
        CMP_EQ   = 3'd1,
        CMP_NE   = 3'd2,
        CMP_LT   = 3'd3,
        CMP_GE   = 3'd4,
        CMP_LTU  = 3'd5,
        CMP_GEU  = 3'd6,
        CMP_TRUE = 3'd7
    } cmp_op_e;

    typedef enum logic [2:0] {
        ALU_PASS_B = 3'd0,
        ALU_ADD    = 3'd1,
        ALU_SUB    = 3'd2,
        ALU_AND    = 3'd3,
        ALU_OR     = 3'd4,
        ALU_XOR    = 3'd5
    } alu_op_e;

    // imm is sign extended wherever it is used
    typedef struct packed {
        opcode_e           opcode;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [8:0]        imm;
    } instr_t;

    // an all-zero word is a bubble
    typedef struct packed {
        cmp_op_e cmp_op;
        alu_op_e alu_op;
        logic    use_imm;
        logic    reads_a;
        logic    reads_b;
        logic    writes_reg;
        logic    mem_read;
        logic    mem_write;
        logic    jump_if_branch;
        logic    link;
        logic    halt;
    } mc_t;

endpackage

/* logic/microcode_rom.sv */
`timescale 1ns/100ps

module microcode_rom import cpu_pkg::*; (
    input  opcode_e opcode,
    output mc_t     mc
);

    always_comb begin
        mc = '0;
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                mc.reads_a    = 1'b1;
                mc.reads_b    = 1'b1;
                mc.writes_reg = 1'b1;
                case (opcode)
                    OP_SUB:  mc.alu_op = ALU_SUB;
                    OP_AND:  mc.alu_op = ALU_AND;
                    OP_OR:   mc.alu_op = ALU_OR;
                    OP_XOR:  mc.alu_op = ALU_XOR;
                    default: mc.alu_op = ALU_ADD;
                endcase
            end
            OP_ADDI, OP_LOAD: begin
                mc.alu_op     = ALU_ADD;
                mc.use_imm    = 1'b1;
                mc.reads_a    = 1'b1;
                mc.writes_reg = 1'b1;
                mc.mem_read   = opcode == OP_LOAD;
            end
            OP_STORE: begin
                // address is rs1 + imm, rs2 travels along as store data
                mc.alu_op    = ALU_ADD;
                mc.use_imm   = 1'b1;
                mc.reads_a   = 1'b1;
                mc.reads_b   = 1'b1;
                mc.mem_write = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGEU: begin
                mc.reads_a        = 1'b1;
                mc.reads_b        = 1'b1;
                mc.jump_if_branch = 1'b1;
                case (opcode)
                    OP_BNE:  mc.cmp_op = CMP_NE;
                    OP_BLT:  mc.cmp_op = CMP_LT;
                    OP_BGEU: mc.cmp_op = CMP_GEU;
                    default: mc.cmp_op = CMP_EQ;
                endcase
            end
            OP_JAL: begin
                mc.cmp_op         = CMP_TRUE;
                mc.jump_if_branch = 1'b1;
                mc.writes_reg     = 1'b1;
                mc.link           = 1'b1;
            end
            OP_HALT: begin
                mc.halt = 1'b1;
            end
            default: begin
                // NOP and unassigned opcodes stay a bubble
                mc = '0;
            end
        endcase
    end

endmodule

/* logic/data_dep_detector.sv */
`timescale 1ns/100ps

module data_dep_detector import cpu_pkg::*; (
    input  mc_t    mc_s0,
    input  mc_t    mc_s1,
    input  mc_t    mc_s2,
    input  mc_t    mc_s3,
    input  instr_t inst_s0,
    input  instr_t inst_s1,
    input  instr_t inst_s2,
    input  instr_t inst_s3,
    output logic   data_dependency
);

    // stages behind decode whose results are not yet in the register file
    mc_t    mc_later   [1:NUM_STAGES-1];
    instr_t inst_later [1:NUM_STAGES-1];

    assign mc_later[1]   = mc_s1;
    assign mc_later[2]   = mc_s2;
    assign mc_later[3]   = mc_s3;
    assign inst_later[1] = inst_s1;
    assign inst_later[2] = inst_s2;
    assign inst_later[3] = inst_s3;

    always_comb begin
        data_dependency = 1'b0;
        for (int i = 1; i < NUM_STAGES; i++) begin
            // register 0 is hardwired to zero so writes to it never matter
            if (mc_later[i].writes_reg && inst_later[i].rd != '0) begin
                if (mc_s0.reads_a && inst_s0.rs1 == inst_later[i].rd) begin
                    data_dependency = 1'b1;
                end
                if (mc_s0.reads_b && inst_s0.rs2 == inst_later[i].rd) begin
                    data_dependency = 1'b1;
                end
            end
        end
    end

endmodule

/* logic/control_unit.sv */
`timescale 1ns/100ps

module control_unit import cpu_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stage_enable,
    output logic [ADDR_WIDTH-1:0] imem_addr,
    input  instr_t                imem_data,
    input  logic [31:0]           reg_a,
    input  logic [31:0]           reg_b,
    input  logic [ADDR_WIDTH-1:0] jmp_addr,
    output mc_t                   mc_s0,
    output mc_t                   mc_s1,
    output mc_t                   mc_s2,
    output mc_t                   mc_s3,
    output instr_t                inst_s0,
    output instr_t                inst_s1,
    output instr_t                inst_s2,
    output instr_t                inst_s3,
    output logic [ADDR_WIDTH-1:0] ret_addr,
    output logic                  halted
);

    logic [ADDR_WIDTH-1:0] pc;
    logic [ADDR_WIDTH-1:0] pc_sf;
    logic [ADDR_WIDTH-1:0] pc_s0;
    logic [ADDR_WIDTH-1:0] pc_s1;
    logic [ADDR_WIDTH-1:0] pc_s2;
    logic                  sf_valid;
    instr_t                skid;
    logic                  skid_valid;
    instr_t                fetched;
    logic                  cmp_true;
    logic [NUM_STAGES-1:0] taken_hist;
    logic                  data_dep;
    logic                  squash;
    logic                  halt_block;
    logic                  dep_hold;
    logic                  blk_s0;
    logic                  fetch_adv;
    logic                  take_branch;

    microcode_rom microcode_rom_i (
        .opcode (inst_s0.opcode),
        .mc     (mc_s0)
    );

    data_dep_detector data_dep_detector_i (
        .mc_s0           (mc_s0),
        .mc_s1           (mc_s1),
        .mc_s2           (mc_s2),
        .mc_s3           (mc_s3),
        .inst_s0         (inst_s0),
        .inst_s1         (inst_s1),
        .inst_s2         (inst_s2),
        .inst_s3         (inst_s3),
        .data_dependency (data_dep)
    );

    assign imem_addr = pc;
    assign ret_addr  = pc_s2 + ADDR_WIDTH'(1);

    // the memory re-reads pc every cycle, so the word meant for sf is kept aside while held
    assign fetched = skid_valid ? skid : imem_data;

    always_comb begin
        // a taken branch kills everything fetched during the next four cycles
        squash      = |taken_hist;
        halt_block  = halted | mc_s1.halt | mc_s2.halt | mc_s3.halt;
        dep_hold    = data_dep & ~squash & ~halt_block;
        blk_s0      = squash | halt_block | data_dep;
        fetch_adv   = stage_enable & ~dep_hold;
        take_branch = taken_hist[1] & mc_s2.jump_if_branch;
    end

    always_comb begin
        case (mc_s0.cmp_op)
            CMP_EQ:   cmp_true = reg_a == reg_b;
            CMP_NE:   cmp_true = reg_a != reg_b;
            CMP_LT:   cmp_true = $signed(reg_a) < $signed(reg_b);
            CMP_GE:   cmp_true = $signed(reg_a) >= $signed(reg_b);
            CMP_LTU:  cmp_true = reg_a < reg_b;
            CMP_GEU:  cmp_true = reg_a >= reg_b;
            CMP_TRUE: cmp_true = 1'b1;
            default:  cmp_true = 1'b0;
        endcase
    end

    // the skid follows every clock, also while a memory access freezes the stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            skid_valid <= 1'b0;
        end else begin
            skid_valid <= ~fetch_adv;
        end
    end

    always_ff @(posedge clk) begin
        if (!fetch_adv && !skid_valid) begin
            skid <= imem_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= '0;
            sf_valid   <= 1'b0;
            taken_hist <= '0;
            halted     <= 1'b0;
            inst_s0    <= '0;
            inst_s1    <= '0;
            inst_s2    <= '0;
            inst_s3    <= '0;
            mc_s1      <= '0;
            mc_s2      <= '0;
            mc_s3      <= '0;
        end else if (stage_enable) begin
            if (take_branch) begin
                pc <= jmp_addr;
            end else if (!dep_hold && !halted) begin
                pc <= pc + ADDR_WIDTH'(1);
            end
            if (fetch_adv) begin
                sf_valid <= 1'b1;
                inst_s0  <= sf_valid ? fetched : '0;
            end
            // a blocked instruction must not leave a taken flag behind
            taken_hist <= {taken_hist[NUM_STAGES-2:0], cmp_true & ~blk_s0};
            mc_s1      <= blk_s0 ? '0 : mc_s0;
            inst_s1    <= blk_s0 ? '0 : inst_s0;
            mc_s2      <= mc_s1;
            inst_s2    <= inst_s1;
            mc_s3      <= mc_s2;
            inst_s3    <= inst_s2;
            if (mc_s3.halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_adv) begin
            pc_sf <= pc;
            pc_s0 <= pc_sf;
        end
        if (stage_enable) begin
            pc_s1 <= pc_s0;
            pc_s2 <= pc_s1;
        end
    end

endmodule

/* logic/register_file.sv */
`timescale 1ns/100ps

module register_file import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [REG_AW-1:0] rd_addr_a,
    input  logic [REG_AW-1:0] rd_addr_b,
    output logic [31:0]       rd_data_a,
    output logic [31:0]       rd_data_b,
    input  logic              wr_en,
    input  logic [REG_AW-1:0] wr_addr,
    input  logic [31:0]       wr_data
);

    logic [31:0] regs [REG_COUNT];

    // no bypass, a value written this cycle is seen on the next one
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            // register 0 is never written and keeps its reset value of zero
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage import cpu_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mc_t                   mc_s1,
    input  mc_t                   mc_s2,
    input  mc_t                   mc_s3,
    input  instr_t                inst_s1,
    input  instr_t                inst_s2,
    input  instr_t                inst_s3,
    input  logic [31:0]           reg_a,
    input  logic [31:0]           reg_b,
    input  logic [ADDR_WIDTH-1:0] ret_addr,
    output logic [ADDR_WIDTH-1:0] jmp_addr,
    output logic                  mem_stall,
    output logic                  wr_en,
    output logic [REG_AW-1:0]     wr_addr,
    output logic [31:0]           wr_data,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [31:0]           wb_adr,
    output logic [31:0]           wb_dat_w,
    input  logic [31:0]           wb_dat_r,
    input  logic                  wb_ack
);

    logic        advance;
    logic        mem_req_s1;
    logic        mem_req_s2;
    logic [31:0] opa_s1;
    logic [31:0] opb_s1;
    logic [31:0] alu_b;
    logic [31:0] alu_s1;
    logic [31:0] alu_s2;
    logic [31:0] store_s2;
    logic [31:0] alu_s3;
    logic [31:0] load_s3;
    logic [31:0] ret_s3;

    assign advance    = ~mem_stall;
    assign mem_req_s1 = mc_s1.mem_read | mc_s1.mem_write;
    assign mem_req_s2 = mc_s2.mem_read | mc_s2.mem_write;

    // ret_addr belongs to the instruction in s2, one past its own pc
    assign jmp_addr = ret_addr - ADDR_WIDTH'(1) + ADDR_WIDTH'($signed(inst_s2.imm));

    always_comb begin
        alu_b = mc_s1.use_imm ? 32'($signed(inst_s1.imm)) : opb_s1;
        case (mc_s1.alu_op)
            ALU_ADD: alu_s1 = opa_s1 + alu_b;
            ALU_SUB: alu_s1 = opa_s1 - alu_b;
            ALU_AND: alu_s1 = opa_s1 & alu_b;
            ALU_OR:  alu_s1 = opa_s1 | alu_b;
            ALU_XOR: alu_s1 = opa_s1 ^ alu_b;
            default: alu_s1 = alu_b;
        endcase
    end

    // address, data and we come from frozen s2 registers, so they hold during wait states
    assign wb_stb   = wb_cyc;
    assign wb_we    = wb_cyc & mc_s2.mem_write;
    assign wb_adr   = alu_s2;
    assign wb_dat_w = store_s2;

    // an access that follows right after an ack starts one cycle late, keeping cyc low between
    assign mem_stall = wb_cyc ? ~wb_ack : mem_req_s2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_cyc <= 1'b0;
        end else if (wb_cyc) begin
            wb_cyc <= ~wb_ack;
        end else begin
            wb_cyc <= mem_req_s2 | mem_req_s1;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            opa_s1   <= reg_a;
            opb_s1   <= reg_b;
            alu_s2   <= alu_s1;
            store_s2 <= opb_s1;
            alu_s3   <= alu_s2;
            load_s3  <= wb_dat_r;
            ret_s3   <= 32'(ret_addr);
        end
    end

    assign wr_en   = mc_s3.writes_reg;
    assign wr_addr = inst_s3.rd;

    always_comb begin
        if (mc_s3.link) begin
            wr_data = ret_s3;
        end else if (mc_s3.mem_read) begin
            wr_data = load_s3;
        end else begin
            wr_data = alu_s3;
        end
    end

endmodule

/* logic/cpu_core.sv */
`timescale 1ns/100ps

module cpu_core import cpu_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic [ADDR_WIDTH-1:0] imem_addr,
    input  instr_t                imem_data,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [31:0]           wb_adr,
    output logic [31:0]           wb_dat_w,
    input  logic [31:0]           wb_dat_r,
    input  logic                  wb_ack,
    output logic                  halted
);

    mc_t                   mc_s1;
    mc_t                   mc_s2;
    mc_t                   mc_s3;
    instr_t                inst_s0;
    instr_t                inst_s1;
    instr_t                inst_s2;
    instr_t                inst_s3;
    logic [31:0]           reg_a;
    logic [31:0]           reg_b;
    logic [ADDR_WIDTH-1:0] jmp_addr;
    logic [ADDR_WIDTH-1:0] ret_addr;
    logic                  mem_stall;
    logic                  stage_enable;
    logic                  wr_en;
    logic [REG_AW-1:0]     wr_addr;
    logic [31:0]           wr_data;

    // every pipeline register holds while a data access waits for ack
    assign stage_enable = ~mem_stall;

    control_unit #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) control_unit_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .stage_enable (stage_enable),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .reg_a        (reg_a),
        .reg_b        (reg_b),
        .jmp_addr     (jmp_addr),
        .mc_s0        (),
        .mc_s1        (mc_s1),
        .mc_s2        (mc_s2),
        .mc_s3        (mc_s3),
        .inst_s0      (inst_s0),
        .inst_s1      (inst_s1),
        .inst_s2      (inst_s2),
        .inst_s3      (inst_s3),
        .ret_addr     (ret_addr),
        .halted       (halted)
    );

    register_file register_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (inst_s0.rs1),
        .rd_addr_b (inst_s0.rs2),
        .rd_data_a (reg_a),
        .rd_data_b (reg_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    execute_stage #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) execute_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mc_s1     (mc_s1),
        .mc_s2     (mc_s2),
        .mc_s3     (mc_s3),
        .inst_s1   (inst_s1),
        .inst_s2   (inst_s2),
        .inst_s3   (inst_s3),
        .reg_a     (reg_a),
        .reg_b     (reg_b),
        .ret_addr  (ret_addr),
        .jmp_addr  (jmp_addr),
        .mem_stall (mem_stall),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

endmodule

/* sim/cpu_core_assert.sv */
`timescale 1ns/100ps

module cpu_core_assert #(
    parameter int ADDR_WIDTH = 10
) (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  wb_cyc,
    input logic                  wb_stb,
    input logic                  wb_we,
    input logic [31:0]           wb_adr,
    input logic [31:0]           wb_dat_w,
    input logic                  wb_ack,
    input logic [ADDR_WIDTH-1:0] imem_addr,
    input logic                  stage_enable
);

    // a strobe is only legal inside a bus cycle
    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
        else $error("wb_stb is high while wb_cyc is low");

    // the request must not move while the slave inserts wait states
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat_w) && $stable(wb_we))
        else $error("wishbone request changed before wb_ack");

    cyc_ends: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_cyc)
        else $error("wb_cyc is still high in the cycle after wb_ack");

    fetch_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        !stage_enable |=> $stable(imem_addr))
        else $error("imem_addr moved while the pipeline was stalled");

endmodule

/* sim/cpu_core_tb.sv */
`timescale 1ns/100ps

module cpu_core_tb import cpu_pkg::*; ();

    localparam int ADDR_WIDTH  = 10;
    localparam int PROG_LEN    = 200;
    localparam int DMEM_WORDS  = 256;
    localparam int CYCLE_LIMIT = 16 + PROG_LEN * 12 + 100;

    logic                  clk = 1'b0;
    logic                  rst_n = 1'b0;
    logic [ADDR_WIDTH-1:0] imem_addr;
    instr_t                imem_data = '0;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [31:0]           wb_adr;
    logic [31:0]           wb_dat_w;
    logic [31:0]           wb_dat_r = '0;
    logic                  wb_ack = 1'b0;
    logic                  halted;

    logic [31:0]           lfsr = 32'h8fcf_316a;
    instr_t                prog [1 << ADDR_WIDTH];
    logic [1:0]            wait_table [256];
    logic [31:0]           dmem [DMEM_WORDS];
    logic [31:0]           model_mem [DMEM_WORDS];
    logic [31:0]           model_regs [REG_COUNT];
    logic [31:0]           exp_store_adr [$];
    logic [31:0]           exp_store_dat [$];
    logic [31:0]           exp_load_adr [$];
    int                    store_idx = 0;
    int                    load_idx = 0;
    int                    cycles = 0;
    logic [7:0]            access_cnt = '0;
    logic [1:0]            wait_left = '0;
    logic                  acc_busy = 1'b0;
    logic [ADDR_WIDTH-1:0] fetch_addr_q = '0;
    logic [ADDR_WIDTH-1:0] halt_pc;

    always #10 clk = ~clk;

    cpu_core #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) cpu_core_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .halted    (halted)
    );

    bind cpu_core cpu_core_assert #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) cpu_core_assert_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_ack       (wb_ack),
        .imem_addr    (imem_addr),
        .stage_enable (stage_enable)
    );

    // galois form, taps x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] next_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return value;
    endfunction

    function automatic logic [31:0] initial_word(input int a);
        return (32'(a) * 32'h9e37_79b9) ^ 32'h5a3c_0f1e;
    endfunction

    function automatic instr_t make_instr(input opcode_e op, input logic [3:0] rd,
                                          input logic [3:0] rs1, input logic [3:0] rs2,
                                          input logic [8:0] imm);
        instr_t ins;
        ins.opcode = op;
        ins.rd     = rd;
        ins.rs1    = rs1;
        ins.rs2    = rs2;
        ins.imm    = imm;
        return ins;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED at %0d ns: %s is 0x%08h, expected 0x%08h",
                                $time, name, actual, expected));
        end
    endtask

    task automatic build_program();
        instr_t     ins;
        logic [3:0] sel;
        logic [3:0] prev_rd;
        prev_rd = 4'd1;
        // beyond the program every word is a HALT whose spare fields carry the address
        for (int a = 0; a < (1 << ADDR_WIDTH); a++) begin
            prog[ADDR_WIDTH'(a)] = make_instr(OP_HALT, 4'(a >> 6), 4'(a >> 2), 4'(a), 9'(a));
        end
        for (int i = 1; i < REG_COUNT; i++) begin
            prog[ADDR_WIDTH'(i - 1)] = make_instr(OP_LOAD, 4'(i), 4'd0, 4'd0, 9'(next_bits(9)));
        end
        for (int p = REG_COUNT - 1; p < PROG_LEN - REG_COUNT; p++) begin
            sel     = 4'(next_bits(4));
            ins.rd  = 4'(next_bits(4));
            ins.rs1 = 4'(next_bits(4));
            ins.rs2 = 4'(next_bits(4));
            ins.imm = 9'(next_bits(9));
            // about half the time the first source is the previous destination
            if (next_bits(1) == 32'd1) begin
                ins.rs1 = prev_rd;
            end
            case (sel)
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4: ins.opcode = opcode_e'(sel + 4'd1);
                4'd5, 4'd6:  ins.opcode = OP_ADDI;
                4'd7, 4'd8:  ins.opcode = OP_LOAD;
                4'd9, 4'd10: ins.opcode = OP_STORE;
                4'd11:       ins.opcode = OP_BEQ;
                4'd12:       ins.opcode = OP_BNE;
                4'd13:       ins.opcode = OP_BLT;
                4'd14:       ins.opcode = OP_BGEU;
                default:     ins.opcode = OP_JAL;
            endcase
            // branch and jump offsets stay forward, 1 to 8 words
            if (sel >= 4'd11) begin
                ins.imm = 9'(next_bits(3) + 32'd1);
            end
            prog[ADDR_WIDTH'(p)] = ins;
            prev_rd = ins.rd;
        end
        for (int i = 1; i < REG_COUNT; i++) begin
            prog[ADDR_WIDTH'(PROG_LEN - REG_COUNT + i - 1)] =
                make_instr(OP_STORE, 4'd0, 4'd0, 4'(i), 9'(i + 64));
        end
        prog[ADDR_WIDTH'(PROG_LEN - 1)] = make_instr(OP_HALT, 4'd0, 4'd0, 4'd0, 9'd0);
        for (int k = 0; k < 256; k++) begin
            wait_table[8'(k)] = 2'(next_bits(2));
        end
    endtask

    task automatic write_model_reg(input logic [3:0] rd, input logic [31:0] value);
        if (rd != 4'd0) begin
            model_regs[rd] = value;
        end
    endtask

    // architectural interpreter, one instruction per loop pass
    task automatic run_model();
        instr_t      ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] addr;
        logic        taken;
        logic        done;
        int          pc;
        pc = 0;
        done = 1'b0;
        for (int r = 0; r < REG_COUNT; r++) begin
            model_regs[4'(r)] = '0;
        end
        for (int m = 0; m < DMEM_WORDS; m++) begin
            model_mem[8'(m)] = initial_word(m);
        end
        while (!done) begin
            ins   = prog[ADDR_WIDTH'(pc)];
            a     = model_regs[ins.rs1];
            b     = model_regs[ins.rs2];
            simm  = {{23{ins.imm[8]}}, ins.imm};
            addr  = a + simm;
            taken = 1'b0;
            case (ins.opcode)
                OP_ADD:  write_model_reg(ins.rd, a + b);
                OP_SUB:  write_model_reg(ins.rd, a - b);
                OP_AND:  write_model_reg(ins.rd, a & b);
                OP_OR:   write_model_reg(ins.rd, a | b);
                OP_XOR:  write_model_reg(ins.rd, a ^ b);
                OP_ADDI: write_model_reg(ins.rd, addr);
                OP_LOAD: begin
                    exp_load_adr.push_back(addr);
                    write_model_reg(ins.rd, model_mem[addr[7:0]]);
                end
                OP_STORE: begin
                    exp_store_adr.push_back(addr);
                    exp_store_dat.push_back(b);
                    model_mem[addr[7:0]] = b;
                end
                OP_BEQ:  taken = a == b;
                OP_BNE:  taken = a != b;
                OP_BLT:  taken = $signed(a) < $signed(b);
                OP_BGEU: taken = a >= b;
                OP_JAL: begin
                    write_model_reg(ins.rd, 32'(pc + 1));
                    taken = 1'b1;
                end
                OP_HALT: done = 1'b1;
                default: begin
                end
            endcase
            pc = taken ? pc + int'(simm) : pc + 1;
        end
    endtask

    // synchronous instruction memory, data follows the address by one cycle
    always @(negedge clk) begin
        imem_data <= prog[fetch_addr_q];
        fetch_addr_q = imem_addr;
    end

    // wishbone slave with 0 to 3 wait states per access
    always @(negedge clk) begin
        if (!rst_n) begin
            for (int a = 0; a < DMEM_WORDS; a++) begin
                dmem[8'(a)] = initial_word(a);
            end
            wb_ack <= 1'b0;
            acc_busy = 1'b0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_stb) begin
            if (!acc_busy) begin
                acc_busy = 1'b1;
                wait_left = wait_table[access_cnt];
                access_cnt = access_cnt + 8'd1;
            end
            if (wait_left != 2'd0) begin
                wait_left = wait_left - 2'd1;
            end else if (wb_we && store_idx >= exp_store_adr.size()) begin
                abort_run("the core stored more words than the reference model");
            end else if (!wb_we && load_idx >= exp_load_adr.size()) begin
                abort_run("the core loaded more words than the reference model");
            end else begin
                acc_busy = 1'b0;
                wb_ack <= 1'b1;
                if (wb_we) begin
                    check_value("wb_adr", wb_adr, exp_store_adr[store_idx]);
                    check_value("wb_dat_w", wb_dat_w, exp_store_dat[store_idx]);
                    dmem[wb_adr[7:0]] = wb_dat_w;
                    store_idx = store_idx + 1;
                end else begin
                    check_value("wb_adr", wb_adr, exp_load_adr[load_idx]);
                    wb_dat_r <= dmem[wb_adr[7:0]];
                    load_idx = load_idx + 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            abort_run($sformatf("timeout: the core did not halt within %0d cycles",
                                CYCLE_LIMIT));
        end
    end

    initial begin
        rst_n = 1'b0;
        build_program();
        run_model();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        while (!halted) begin
            @(negedge clk);
        end
        halt_pc = imem_addr;
        repeat (8) @(negedge clk);
        check_value("imem_addr", 32'(imem_addr), 32'(halt_pc));
        check_value("halted", 32'(halted), 32'd1);
        check_value("store count", 32'(store_idx), 32'(exp_store_adr.size()));
        check_value("load count", 32'(load_idx), 32'(exp_load_adr.size()));
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* src.f */
logic/cpu_pkg.sv
logic/microcode_rom.sv
logic/data_dep_detector.sv
logic/control_unit.sv
logic/register_file.sv
logic/execute_stage.sv
logic/cpu_core.sv
sim/cpu_core_assert.sv
sim/cpu_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpu_core_tb -f src.f -o cpu_core_sim || exit 1
out=$(./obj_dir/cpu_core_sim 2>&1)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1
